//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_B, BR_BL, BR_JIRL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_kind_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_UI5, IMM_UI12, IMM_SI12, IMM_SI20_HI, IMM_FOUR
    } imm_kind_e;

    // field lsb positions
    // immediates start at rk (i12, i16) or rj (i20)
    localparam int OP6_LSB = 26;
    localparam int OP4_LSB = 22;
    localparam int OP2_LSB = 20;
    localparam int OP5_LSB = 15;
    localparam int RK_LSB  = 10;
    localparam int RJ_LSB  = 5;
    localparam int RD_LSB  = 0;

    // bits [31:26]
    localparam logic [5:0] OP6_ALU = 6'h00, OP6_LU12I = 6'h05, OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM = 6'h0a, OP6_JIRL = 6'h13, OP6_B = 6'h14, OP6_BL = 6'h15;
    localparam logic [5:0] OP6_BEQ = 6'h16, OP6_BNE = 6'h17, OP6_BLT = 6'h18;
    localparam logic [5:0] OP6_BGE = 6'h19, OP6_BLTU = 6'h1a, OP6_BGEU = 6'h1b;

    // bits [25:22]
    localparam logic [3:0] OP4_REG3 = 4'h0, OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_SLTI = 4'h8, OP4_SLTUI = 4'h9, OP4_ADDI = 4'ha;
    localparam logic [3:0] OP4_ANDI = 4'hd, OP4_ORI = 4'he, OP4_XORI = 4'hf;
    localparam logic [3:0] OP4_LD_W = 4'h2, OP4_ST_W = 4'h6;  // under OP6_MEM

    // bits [21:20]
    localparam logic [1:0] OP2_REG3 = 2'h1, OP2_SHIFTI = 2'h0;

    // bits [19:15]
    localparam logic [4:0] OP5_ADD = 5'h00, OP5_SUB = 5'h02, OP5_SLT = 5'h04, OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR = 5'h08, OP5_AND = 5'h09, OP5_OR = 5'h0a, OP5_XOR = 5'h0b;
    localparam logic [4:0] OP5_SLL = 5'h0e, OP5_SRL = 5'h0f, OP5_SRA = 5'h10;
    localparam logic [4:0] OP5_SLLI = 5'h01, OP5_SRLI = 5'h09, OP5_SRAI = 5'h11;

endpackage

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // one result bypass source
    typedef struct packed {
        logic              we;
        isa_pkg::reg_addr_t dest;
        isa_pkg::xlen_t     data;
    } fwd_t;

    localparam isa_pkg::reg_addr_t RA_REG = 5'd1;  // link register of bl

    localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

//--- source/decode_if.sv
`default_nettype none

interface decode_if;
    import isa_pkg::*;

    reg_addr_t raddr1;      // rj
    reg_addr_t raddr2;      // rd or rk
    logic      uses_r1;
    logic      uses_r2;
    alu_op_e   alu_op;
    xlen_t     imm;
    logic      src1_is_pc;
    logic      src2_is_imm;
    br_kind_e  br_kind;
    xlen_t     br_offs;
    logic      gr_we;
    reg_addr_t dest;
    logic      mem_we;
    logic      is_load;

    modport dec (
        output raddr1, raddr2, uses_r1, uses_r2, alu_op, imm, src1_is_pc, src2_is_imm,
        output br_kind, br_offs, gr_we, dest, mem_we, is_load
    );

    modport opnd (input raddr1, raddr2, uses_r1, uses_r2);

    modport iss (
        input alu_op, imm, src1_is_pc, src2_is_imm, br_kind, br_offs,
        input gr_we, dest, mem_we, is_load
    );

endinterface

`default_nettype wire

//--- source/id_latch.sv
`default_nettype none

module id_latch (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             fs_valid,
    input  wire             [31:0] fs_pc,
    input  wire             [31:0] fs_inst,
    input  wire             ready_go,
    input  wire             es_allowin,
    output logic            ds_allowin,
    output logic            ds_valid,
    output isa_pkg::xlen_t  ds_pc,
    output isa_pkg::xlen_t  ds_inst
);

    // empty, or the current item leaves this cycle
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input wire isa_pkg::xlen_t ds_inst,
    decode_if.dec              dif
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    alu_op_e     alu_op;
    imm_kind_e   imm_kind;
    br_kind_e    br_kind;
    logic        src1_is_pc;
    logic        is_load;
    logic        is_store;
    logic        cond_br;

    assign op6 = ds_inst[OP6_LSB +: 6];
    assign op4 = ds_inst[OP4_LSB +: 4];
    assign op2 = ds_inst[OP2_LSB +: 2];
    assign op5 = ds_inst[OP5_LSB +: 5];
    assign rd  = ds_inst[RD_LSB +: 5];
    assign rj  = ds_inst[RJ_LSB +: 5];
    assign rk  = ds_inst[RK_LSB +: 5];

    always_comb begin
        alu_op     = ALU_NONE;  // unknown stays a no-op
        imm_kind   = IMM_NONE;
        br_kind    = BR_NONE;
        src1_is_pc = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        case (op6)
            OP6_ALU: begin
                if (op4 == OP4_REG3 && op2 == OP2_REG3) begin
                    case (op5)
                        OP5_ADD:  alu_op = ALU_ADD;
                        OP5_SUB:  alu_op = ALU_SUB;
                        OP5_SLT:  alu_op = ALU_SLT;
                        OP5_SLTU: alu_op = ALU_SLTU;
                        OP5_NOR:  alu_op = ALU_NOR;
                        OP5_AND:  alu_op = ALU_AND;
                        OP5_OR:   alu_op = ALU_OR;
                        OP5_XOR:  alu_op = ALU_XOR;
                        OP5_SLL:  alu_op = ALU_SLL;
                        OP5_SRL:  alu_op = ALU_SRL;
                        OP5_SRA:  alu_op = ALU_SRA;
                        default:  alu_op = ALU_NONE;
                    endcase
                end else if (op4 == OP4_SHIFTI && op2 == OP2_SHIFTI) begin
                    imm_kind = IMM_UI5;
                    case (op5)
                        OP5_SLLI: alu_op = ALU_SLL;
                        OP5_SRLI: alu_op = ALU_SRL;
                        OP5_SRAI: alu_op = ALU_SRA;
                        default:  alu_op = ALU_NONE;
                    endcase
                end else begin
                    case (op4)
                        OP4_SLTI:  alu_op = ALU_SLT;
                        OP4_SLTUI: alu_op = ALU_SLTU;
                        OP4_ADDI:  alu_op = ALU_ADD;
                        OP4_ANDI:  alu_op = ALU_AND;
                        OP4_ORI:   alu_op = ALU_OR;
                        OP4_XORI:  alu_op = ALU_XOR;
                        default:   alu_op = ALU_NONE;
                    endcase
                    if (op4 inside {OP4_SLTI, OP4_SLTUI, OP4_ADDI}) imm_kind = IMM_SI12;
                    else if (op4 inside {OP4_ANDI, OP4_ORI, OP4_XORI}) imm_kind = IMM_UI12;
                end
            end
            OP6_LU12I, OP6_PCADDU12I: begin
                if (!ds_inst[25]) begin
                    alu_op     = (op6 == OP6_LU12I) ? ALU_LUI : ALU_ADD;
                    imm_kind   = IMM_SI20_HI;
                    src1_is_pc = (op6 == OP6_PCADDU12I);
                end
            end
            OP6_MEM: begin
                if (op4 == OP4_LD_W || op4 == OP4_ST_W) begin
                    alu_op   = ALU_ADD;   // address calc
                    imm_kind = IMM_SI12;
                    is_load  = (op4 == OP4_LD_W);
                    is_store = (op4 == OP4_ST_W);
                end
            end
            OP6_JIRL: br_kind = BR_JIRL;
            OP6_B:    br_kind = BR_B;
            OP6_BL:   br_kind = BR_BL;
            OP6_BEQ:  br_kind = BR_BEQ;
            OP6_BNE:  br_kind = BR_BNE;
            OP6_BLT:  br_kind = BR_BLT;
            OP6_BGE:  br_kind = BR_BGE;
            OP6_BLTU: br_kind = BR_BLTU;
            OP6_BGEU: br_kind = BR_BGEU;
            default:  br_kind = BR_NONE;
        endcase
        // link value pc + 4
        if (br_kind == BR_JIRL || br_kind == BR_BL) begin
            alu_op     = ALU_ADD;
            imm_kind   = IMM_FOUR;
            src1_is_pc = 1'b1;
        end
    end

    assign cond_br = br_kind inside {[BR_BEQ:BR_BGEU]};

    always_comb begin
        case (imm_kind)
            IMM_UI5:     dif.imm = {27'b0, ds_inst[RK_LSB +: 5]};
            IMM_UI12:    dif.imm = {20'b0, ds_inst[RK_LSB +: 12]};
            IMM_SI12:    dif.imm = {{20{ds_inst[21]}}, ds_inst[RK_LSB +: 12]};
            IMM_SI20_HI: dif.imm = {ds_inst[RJ_LSB +: 20], 12'b0};
            IMM_FOUR:    dif.imm = 32'd4;
            default:     dif.imm = '0;
        endcase
    end

    // offs26 is split with its high part in [9:0]
    assign dif.br_offs = (br_kind == BR_B || br_kind == BR_BL)
                       ? {{4{ds_inst[9]}}, ds_inst[9:0], ds_inst[RK_LSB +: 16], 2'b0}
                       : {{14{ds_inst[25]}}, ds_inst[RK_LSB +: 16], 2'b0};

    assign dif.raddr1      = rj;
    assign dif.raddr2      = (cond_br || is_store) ? rd : rk;
    assign dif.uses_r1     = (alu_op != ALU_NONE && alu_op != ALU_LUI && !src1_is_pc)
                           || cond_br || br_kind == BR_JIRL;
    assign dif.uses_r2     = (alu_op != ALU_NONE && imm_kind == IMM_NONE) || is_store || cond_br;
    assign dif.alu_op      = alu_op;
    assign dif.src1_is_pc  = src1_is_pc;
    assign dif.src2_is_imm = (imm_kind != IMM_NONE);
    assign dif.br_kind     = br_kind;
    assign dif.gr_we       = (alu_op != ALU_NONE) && !is_store;
    assign dif.dest        = (br_kind == BR_BL) ? RA_REG : rd;
    assign dif.mem_we      = is_store;
    assign dif.is_load     = is_load;

endmodule

`default_nettype wire

//--- source/operand_fetch.sv
`default_nettype none

module operand_fetch (
    input  wire                  clk,
    input  wire pipe_pkg::fwd_t  exe_fwd,
    input  wire pipe_pkg::fwd_t  mem_fwd,
    input  wire pipe_pkg::fwd_t  wb_fwd,
    input  wire                  exe_is_load,
    decode_if.opnd               dif,
    output isa_pkg::xlen_t       rj_value,
    output isa_pkg::xlen_t       rkd_value,
    output logic                 ready_go
);
    import isa_pkg::*;
    import pipe_pkg::*;

    xlen_t rf [NUM_REGS];
    logic  load_hit;

    // newest producer wins and r0 reads zero
    function automatic xlen_t fwd_pick(reg_addr_t addr, xlen_t rf_val,
                                       fwd_t e, fwd_t m, fwd_t w);
        if (addr == '0) return '0;
        if (e.we && e.dest == addr) return e.data;
        if (m.we && m.dest == addr) return m.data;
        if (w.we && w.dest == addr) return w.data;
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_fwd.we && wb_fwd.dest != '0) begin
            rf[wb_fwd.dest] <= wb_fwd.data;
        end
    end

    assign rj_value  = fwd_pick(dif.raddr1, rf[dif.raddr1], exe_fwd, mem_fwd, wb_fwd);
    assign rkd_value = fwd_pick(dif.raddr2, rf[dif.raddr2], exe_fwd, mem_fwd, wb_fwd);

    // load data not ready until MEM
    assign load_hit = exe_is_load && exe_fwd.dest != '0
                   && ((dif.uses_r1 && exe_fwd.dest == dif.raddr1)
                    || (dif.uses_r2 && exe_fwd.dest == dif.raddr2));

    assign ready_go = !load_hit;

endmodule

`default_nettype wire

//--- source/id_issue.sv
`default_nettype none

module id_issue (
    input  wire                  ds_valid,
    input  wire isa_pkg::xlen_t  ds_pc,
    input  wire isa_pkg::xlen_t  rj_value,
    input  wire isa_pkg::xlen_t  rkd_value,
    input  wire                  ready_go,
    input  wire                  es_allowin,
    decode_if.iss                dif,
    output logic                 es_valid,
    output isa_pkg::xlen_t       es_src1,
    output isa_pkg::xlen_t       es_src2,
    output isa_pkg::xlen_t       es_store_data,
    output isa_pkg::alu_op_e     es_alu_op,
    output logic                 es_gr_we,
    output isa_pkg::reg_addr_t   es_dest,
    output logic                 es_mem_we,
    output logic                 es_is_load,
    output logic                 br_taken,
    output isa_pkg::xlen_t       br_target
);
    import isa_pkg::*;

    logic [32:0] sub;
    logic        eq;
    logic        lt;
    logic        ltu;
    logic        cond;

    assign sub = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;  // rj - rkd
    assign eq  = ~|sub[31:0];
    assign lt  = rj_value[31] ^ ~rkd_value[31] ^ sub[32];
    assign ltu = ~sub[32];

    always_comb begin
        case (dif.br_kind)
            BR_B, BR_BL, BR_JIRL: cond = 1'b1;
            BR_BEQ:  cond = eq;
            BR_BNE:  cond = !eq;
            BR_BLT:  cond = lt;
            BR_BGE:  cond = !lt;
            BR_BLTU: cond = ltu;
            BR_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    // strobe only on the cycle the branch moves on
    assign br_taken  = cond && ds_valid && ready_go && es_allowin;
    assign br_target = ((dif.br_kind == BR_JIRL) ? rj_value : ds_pc) + dif.br_offs;

    assign es_valid      = ds_valid && ready_go;
    assign es_src1       = dif.src1_is_pc ? ds_pc : rj_value;
    assign es_src2       = dif.src2_is_imm ? dif.imm : rkd_value;
    assign es_store_data = rkd_value;
    assign es_alu_op     = dif.alu_op;
    assign es_gr_we      = dif.gr_we;
    assign es_dest       = dif.dest;
    assign es_mem_we     = dif.mem_we;
    assign es_is_load    = dif.is_load;

endmodule

`default_nettype wire

//--- source/id_stage.sv
`default_nettype none

module id_stage (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        fs_valid,
    input  wire isa_pkg::xlen_t        fs_pc,
    input  wire isa_pkg::xlen_t        fs_inst,
    input  wire                        es_allowin,
    input  wire                        exe_we,
    input  wire isa_pkg::reg_addr_t    exe_dest,
    input  wire isa_pkg::xlen_t        exe_result,
    input  wire                        exe_is_load,
    input  wire                        mem_we,
    input  wire isa_pkg::reg_addr_t    mem_dest,
    input  wire isa_pkg::xlen_t        mem_result,
    input  wire                        wb_we,
    input  wire isa_pkg::reg_addr_t    wb_dest,
    input  wire isa_pkg::xlen_t        wb_data,
    output logic                       ds_allowin,
    output logic                       es_valid,
    output isa_pkg::xlen_t             es_pc,
    output isa_pkg::alu_op_e           es_alu_op,
    output isa_pkg::xlen_t             es_src1,
    output isa_pkg::xlen_t             es_src2,
    output isa_pkg::xlen_t             es_store_data,
    output logic                       es_gr_we,
    output isa_pkg::reg_addr_t         es_dest,
    output logic                       es_mem_we,
    output logic                       es_is_load,
    output logic                       br_taken,
    output isa_pkg::xlen_t             br_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic  ds_valid;
    logic  ready_go;
    xlen_t ds_pc;
    xlen_t ds_inst;
    xlen_t rj_value;
    xlen_t rkd_value;
    fwd_t  exe_fwd;
    fwd_t  mem_fwd;
    fwd_t  wb_fwd;

    decode_if dif ();

    assign exe_fwd = '{we: exe_we, dest: exe_dest, data: exe_result};
    assign mem_fwd = '{we: mem_we, dest: mem_dest, data: mem_result};
    assign wb_fwd  = '{we: wb_we, dest: wb_dest, data: wb_data};

    assign es_pc = ds_pc;

    // remaining ports connect by matching names
    id_latch id_latch_inst (.*);

    inst_decoder inst_decoder_inst (.dif(dif), .*);

    operand_fetch operand_fetch_inst (.dif(dif), .*);

    id_issue id_issue_inst (.dif(dif), .*);

endmodule

`default_nettype wire

//--- sim/tb_id_stage.sv
`default_nettype none

module tb_id_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int TEST_CYCLES = 200;  // all tests need about 110 cycles
    localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

    logic      clk;
    logic      arst_n;
    logic      fs_valid;
    xlen_t     fs_pc;
    xlen_t     fs_inst;
    logic      es_allowin;
    logic      exe_we;
    reg_addr_t exe_dest;
    xlen_t     exe_result;
    logic      exe_is_load;
    logic      mem_we;
    reg_addr_t mem_dest;
    xlen_t     mem_result;
    logic      wb_we;
    reg_addr_t wb_dest;
    xlen_t     wb_data;
    logic      ds_allowin;
    logic      es_valid;
    xlen_t     es_pc;
    alu_op_e   es_alu_op;
    xlen_t     es_src1;
    xlen_t     es_src2;
    xlen_t     es_store_data;
    logic      es_gr_we;
    reg_addr_t es_dest;
    logic      es_mem_we;
    logic      es_is_load;
    logic      br_taken;
    xlen_t     br_target;

    xlen_t rf_model [NUM_REGS];
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic xlen_t reg3(logic [4:0] op5, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
        return {OP6_ALU, OP4_REG3, OP2_REG3, op5, rk, rj, rd};
    endfunction

    function automatic xlen_t shift_imm(logic [4:0] op5, reg_addr_t rd, reg_addr_t rj,
                                        logic [4:0] ui5);
        return {OP6_ALU, OP4_SHIFTI, OP2_SHIFTI, op5, ui5, rj, rd};
    endfunction

    function automatic xlen_t imm12(logic [5:0] op6, logic [3:0] op4, reg_addr_t rd,
                                    reg_addr_t rj, logic [11:0] i12);
        return {op6, op4, i12, rj, rd};
    endfunction

    function automatic xlen_t imm20(logic [5:0] op6, reg_addr_t rd, logic [19:0] si20);
        return {op6, 1'b0, si20, rd};
    endfunction

    function automatic xlen_t br16(logic [5:0] op6, reg_addr_t rj, reg_addr_t rd,
                                   logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    // offs26 high part goes to the low bits
    function automatic xlen_t br26(logic [5:0] op6, logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic cond_taken(logic [5:0] op6, xlen_t a, xlen_t b);
        case (op6)
            OP6_BEQ:  return a == b;
            OP6_BNE:  return a != b;
            OP6_BLT:  return $signed(a) < $signed(b);
            OP6_BGE:  return $signed(a) >= $signed(b);
            OP6_BLTU: return a < b;
            OP6_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_core(input alu_op_e op, input xlen_t s2, input reg_addr_t dest,
                              input logic we, input logic mwe, input logic ld);
        check("es_alu_op", 32'(es_alu_op), 32'(op));
        check("es_src2", es_src2, s2);
        check("es_dest", 32'(es_dest), 32'(dest));
        check("es_gr_we", 32'(es_gr_we), 32'(we));
        check("es_mem_we", 32'(es_mem_we), 32'(mwe));
        check("es_is_load", 32'(es_is_load), 32'(ld));
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // hold fetch until the stage takes the item
    task automatic accept(input xlen_t inst, input xlen_t pc);
        fs_valid = 1'b1;
        fs_inst  = inst;
        fs_pc    = pc;
        while (!ds_allowin) begin
            step();
        end
        step();
        fs_valid = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t addr, input xlen_t data);
        wb_we   = 1'b1;
        wb_dest = addr;
        wb_data = data;
        step();
        wb_we = 1'b0;
        if (addr != 5'd0) rf_model[addr] = data;
    endtask

    task automatic reg_alu_case(input logic [4:0] op5, input alu_op_e op, input reg_addr_t rd,
                                input reg_addr_t rj, input reg_addr_t rk);
        step();
        check("es_valid", 32'(es_valid), 32'd0);  // stage empty before
        accept(reg3(op5, rd, rj, rk), 32'h1c00_0000);
        check("es_valid", 32'(es_valid), 32'd1);
        check("es_pc", es_pc, 32'h1c00_0000);
        check("es_src1", es_src1, rf_model[rj]);
        check_core(op, rf_model[rk], rd, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic reg_alu_ops();
        reg_alu_case(OP5_ADD, ALU_ADD, 5'd5, 5'd6, 5'd7);
        reg_alu_case(OP5_SUB, ALU_SUB, 5'd5, 5'd7, 5'd6);
        reg_alu_case(OP5_SLT, ALU_SLT, 5'd9, 5'd10, 5'd11);
        reg_alu_case(OP5_NOR, ALU_NOR, 5'd12, 5'd13, 5'd14);
        reg_alu_case(OP5_XOR, ALU_XOR, 5'd15, 5'd16, 5'd17);
        reg_alu_case(OP5_SRA, ALU_SRA, 5'd31, 5'd30, 5'd29);
    endtask

    task automatic immediate_ops();
        accept(imm12(OP6_ALU, OP4_ADDI, 5'd8, 5'd9, 12'hffb), 32'h1c00_0010);
        check("es_src1", es_src1, rf_model[9]);
        check_core(ALU_ADD, 32'hffff_fffb, 5'd8, 1'b1, 1'b0, 1'b0);
        accept(imm12(OP6_ALU, OP4_SLTI, 5'd8, 5'd9, 12'h800), 32'h1c00_0014);
        check_core(ALU_SLT, 32'hffff_f800, 5'd8, 1'b1, 1'b0, 1'b0);
        accept(imm12(OP6_ALU, OP4_ANDI, 5'd8, 5'd9, 12'hf0f), 32'h1c00_0018);
        check_core(ALU_AND, 32'h0000_0f0f, 5'd8, 1'b1, 1'b0, 1'b0);
        accept(shift_imm(OP5_SLLI, 5'd8, 5'd9, 5'd13), 32'h1c00_001c);
        check_core(ALU_SLL, 32'd13, 5'd8, 1'b1, 1'b0, 1'b0);
        accept(imm20(OP6_LU12I, 5'd10, 20'h8abcd), 32'h1c00_0020);
        check_core(ALU_LUI, 32'h8abc_d000, 5'd10, 1'b1, 1'b0, 1'b0);
        accept(imm20(OP6_PCADDU12I, 5'd10, 20'h00012), 32'h1c00_0100);
        check("es_src1", es_src1, 32'h1c00_0100);
        check_core(ALU_ADD, 32'h0001_2000, 5'd10, 1'b1, 1'b0, 1'b0);
        accept(imm12(OP6_MEM, OP4_LD_W, 5'd11, 5'd12, 12'h010), 32'h1c00_0104);
        check("es_src1", es_src1, rf_model[12]);
        check_core(ALU_ADD, 32'd16, 5'd11, 1'b1, 1'b0, 1'b1);
        accept(imm12(OP6_MEM, OP4_ST_W, 5'd13, 5'd12, 12'hffc), 32'h1c00_0108);
        check("es_store_data", es_store_data, rf_model[13]);
        check_core(ALU_ADD, 32'hffff_fffc, 5'd13, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic forward_priority();
        step();  // let the previous item leave
        es_allowin = 1'b0;  // keep the item so each level can be dropped
        exe_we     = 1'b1;
        exe_dest   = 5'd20;
        exe_result = 32'h1111_1111;
        mem_we     = 1'b1;
        mem_dest   = 5'd20;
        mem_result = 32'h2222_2222;
        wb_we      = 1'b1;
        wb_dest    = 5'd20;
        wb_data    = 32'h3333_3333;
        accept(reg3(OP5_ADD, 5'd5, 5'd20, 5'd0), 32'h1c00_0200);
        check("es_src1", es_src1, 32'h1111_1111);
        check("es_src2", es_src2, 32'd0);
        exe_we = 1'b0;
        step();
        check("es_src1", es_src1, 32'h2222_2222);
        mem_we = 1'b0;
        step();
        check("es_src1", es_src1, 32'h3333_3333);
        wb_we = 1'b0;
        rf_model[20] = 32'h3333_3333;  // wb port wrote it meanwhile
        step();
        check("es_src1", es_src1, rf_model[20]);
        es_allowin = 1'b1;
        step();
        exe_we     = 1'b1;
        exe_dest   = 5'd0;
        exe_result = 32'hdead_beef;
        accept(reg3(OP5_ADD, 5'd5, 5'd0, 5'd0), 32'h1c00_0204);
        check("es_src1", es_src1, 32'd0);
        check("es_src2", es_src2, 32'd0);
        exe_we = 1'b0;
    endtask

    task automatic load_use_stall();
        exe_we      = 1'b1;
        exe_dest    = 5'd7;
        exe_result  = 32'h5a5a_0007;
        exe_is_load = 1'b1;
        accept(reg3(OP5_ADD, 5'd3, 5'd7, 5'd8), 32'h1c00_0300);
        repeat (3) begin
            check("es_valid", 32'(es_valid), 32'd0);
            check("ds_allowin", 32'(ds_allowin), 32'd0);
            step();
        end
        exe_is_load = 1'b0;  // load data now on the EXE result
        #4;
        check("es_valid", 32'(es_valid), 32'd1);
        check("es_src1", es_src1, 32'h5a5a_0007);
        check("es_src2", es_src2, rf_model[8]);
        check("ds_allowin", 32'(ds_allowin), 32'd1);
        step();
        exe_we = 1'b0;
    endtask

    task automatic branch_resolve();
        xlen_t       pc;
        logic [25:0] offs26;
        logic [5:0]  op6;
        int          rjs [3];
        int          rds [3];
        int          k;
        int          p;
        pc  = 32'h1c00_0400;
        rjs = '{21, 22, 21};
        rds = '{22, 21, 24};
        wb_write(5'd21, 32'h8000_0000);
        wb_write(5'd22, 32'h0000_0001);
        wb_write(5'd24, 32'h8000_0000);
        for (k = 0; k < 6; k++) begin
            for (p = 0; p < 3; p++) begin
                op6 = OP6_BEQ + 6'(k);
                accept(br16(op6, 5'(rjs[p]), 5'(rds[p]), 16'hfff0), pc);
                check("br_taken", 32'(br_taken),
                      32'(cond_taken(op6, rf_model[rjs[p]], rf_model[rds[p]])));
                check("br_target", br_target, pc + 32'hffff_ffc0);
                check("es_gr_we", 32'(es_gr_we), 32'd0);
            end
        end
        offs26 = 26'h3ff_ff00;
        accept(br26(OP6_B, offs26), pc);
        check("br_taken", 32'(br_taken), 32'd1);
        check("br_target", br_target, pc + 32'hffff_fc00);
        check("es_gr_we", 32'(es_gr_we), 32'd0);
        accept(br26(OP6_BL, 26'h000_0040), pc);
        check("br_taken", 32'(br_taken), 32'd1);
        check("br_target", br_target, pc + 32'h0000_0100);
        check("es_src1", es_src1, pc);
        check_core(ALU_ADD, 32'd4, RA_REG, 1'b1, 1'b0, 1'b0);
        accept(br16(OP6_JIRL, 5'd22, 5'd4, 16'h0010), pc);
        check("br_taken", 32'(br_taken), 32'd1);
        check("br_target", br_target, rf_model[22] + 32'h0000_0040);
        check("es_src1", es_src1, pc);
        check_core(ALU_ADD, 32'd4, 5'd4, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic backpressure_hold();
        step();
        es_allowin = 1'b0;
        accept(br16(OP6_BEQ, 5'd21, 5'd24, 16'h0008), 32'h1c00_0500);
        repeat (3) begin
            check("es_valid", 32'(es_valid), 32'd1);
            check("br_taken", 32'(br_taken), 32'd0);
            check("ds_allowin", 32'(ds_allowin), 32'd0);
            check("es_src1", es_src1, rf_model[21]);
            check("es_src2", es_src2, rf_model[24]);
            check("br_target", br_target, 32'h1c00_0520);
            step();
        end
        es_allowin = 1'b1;
        #4;  // mid-cycle after the input change
        check("br_taken", 32'(br_taken), 32'd1);
        step();
        check("br_taken", 32'(br_taken), 32'd0);
        check("es_valid", 32'(es_valid), 32'd0);
    endtask

    initial begin
        int r;
        void'($urandom(32'h5320));
        arst_n      = 1'b0;
        fs_valid    = 1'b0;
        fs_pc       = '0;
        fs_inst     = '0;
        es_allowin  = 1'b1;
        exe_we      = 1'b0;
        exe_dest    = '0;
        exe_result  = '0;
        exe_is_load = 1'b0;
        mem_we      = 1'b0;
        mem_dest    = '0;
        mem_result  = '0;
        wb_we       = 1'b0;
        wb_dest     = '0;
        wb_data     = '0;
        rf_model[0] = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check("ds_allowin", 32'(ds_allowin), 32'd1);
        check("es_valid", 32'(es_valid), 32'd0);
        check("br_taken", 32'(br_taken), 32'd0);
        for (r = 1; r < NUM_REGS; r++) begin
            wb_write(5'(r), $urandom);
        end
        reg_alu_ops();
        immediate_ops();
        forward_priority();
        load_use_stall();
        branch_resolve();
        backpressure_hold();
        step();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- id_stage.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/decode_if.sv
source/id_latch.sv
source/inst_decoder.sv
source/operand_fetch.sv
source/id_issue.sv
source/id_stage.sv
sim/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f id_stage.f --top-module tb_id_stage -Mdir obj_dir

./obj_dir/Vtb_id_stage | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
